// File: design/rover_pkg.sv
`default_nettype none

package rover_pkg;

    // Operating mode of the rover
    typedef enum logic [1:0] {
        MODE_IDLE = 2'd0,
        MODE_CAM  = 2'd1,   // Camera-guided following
        MODE_IR   = 2'd2    // Remote control
    } rover_mode_e;

    // Sub-states used while in camera mode
    typedef enum logic [1:0] {
        CAM_SEARCH = 2'd0,
        CAM_FOLLOW = 2'd1,
        CAM_PAUSE  = 2'd3   // Held whenever mode is not camera
    } cam_state_e;

    // Drive state handed to the motor block
    typedef enum logic [2:0] {
        DRV_STOP   = 3'd0,
        DRV_LEFT   = 3'd1,
        DRV_RIGHT  = 3'd2,
        DRV_SLOW   = 3'd3,
        DRV_MEDIUM = 3'd4,
        DRV_FAST   = 3'd5
    } drive_e;

    // Command decoded from the remote button code
    typedef enum logic [1:0] {
        CMD_NONE = 2'd0,
        CMD_CAM  = 2'd1,
        CMD_IR   = 2'd2,
        CMD_IDLE = 2'd3
    } mode_cmd_e;

    typedef struct packed {
        mode_cmd_e  cmd;
        logic [2:0] cam_dir;   // Tracker direction hint
        logic [1:0] speed;     // Tracker speed hint
        logic       target;    // Debounced orange flag
    } sensor_sample_t;

    typedef struct packed {
        rover_mode_e mode;
        cam_state_e  cam_state;
        drive_e      drive;
    } rover_status_t;

    // Active-low patterns, segment a in bit 0
    typedef struct packed {
        logic [6:0] mode_hi;
        logic [6:0] mode_lo;
        logic [6:0] drive_digit;
    } seg_digits_t;

endpackage

`default_nettype wire

// File: design/sensor_front.sv
`default_nettype none

module sensor_front #(
    parameter int TARGET_FILTER = 4
) (
    input  wire logic                     clk_50,
    input  wire logic                     rst_n,
    input  wire logic [7:0]               ir_button,
    input  wire logic [2:0]               cam_direction,
    input  wire logic [1:0]               cam_speed,
    input  wire logic                     orange_detected,
    output rover_pkg::sensor_sample_t     sample
);
    import rover_pkg::*;

    localparam logic [7:0] BTN_CAM  = 8'h0F;
    localparam logic [7:0] BTN_IR   = 8'h13;
    localparam logic [7:0] BTN_IDLE = 8'h10;
    localparam int         CNT_W    = (TARGET_FILTER > 1) ? $clog2(TARGET_FILTER) : 1;

    mode_cmd_e        cmd_dec;
    mode_cmd_e        cmd_q;
    logic [2:0]       dir_q;
    logic [1:0]       speed_q;
    logic             target_q;
    logic [CNT_W-1:0] mismatch_cnt;   // Consecutive samples that differ from target_q

    always_comb begin
        case (ir_button)
            BTN_CAM:  cmd_dec = CMD_CAM;
            BTN_IR:   cmd_dec = CMD_IR;
            BTN_IDLE: cmd_dec = CMD_IDLE;
            default:  cmd_dec = CMD_NONE;   // Unknown buttons are ignored
        endcase
    end

    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            cmd_q        <= CMD_NONE;
            target_q     <= 1'b0;
            mismatch_cnt <= '0;
        end else begin
            cmd_q <= cmd_dec;
            if (orange_detected == target_q) begin
                mismatch_cnt <= '0;   // Agreement restarts the run
            end else if (mismatch_cnt == CNT_W'(TARGET_FILTER - 1)) begin
                target_q     <= orange_detected;   // Run long enough, accept it
                mismatch_cnt <= '0;
            end else begin
                mismatch_cnt <= mismatch_cnt + CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk_50) begin
        dir_q   <= cam_direction;
        speed_q <= cam_speed;
    end

    assign sample = '{cmd: cmd_q, cam_dir: dir_q, speed: speed_q, target: target_q};

endmodule

`default_nettype wire

// File: design/drive_mode_fsm.sv
`default_nettype none

module drive_mode_fsm (
    input  wire logic                     clk_50,
    input  wire logic                     rst_n,
    input  wire rover_pkg::sensor_sample_t sample,
    output rover_pkg::rover_status_t      status,
    output logic                          track_restart
);
    import rover_pkg::*;

    rover_mode_e next_mode;
    cam_state_e  next_cam;
    drive_e      next_drive;

    always_comb begin
        next_mode = status.mode;   // Hold unless a command moves it
        case (status.mode)
            MODE_IDLE: begin
                if (sample.cmd == CMD_CAM)     next_mode = MODE_CAM;
                else if (sample.cmd == CMD_IR) next_mode = MODE_IR;
            end
            MODE_CAM: begin
                if (sample.cmd == CMD_IR)        next_mode = MODE_IR;
                else if (sample.cmd == CMD_IDLE) next_mode = MODE_IDLE;
            end
            MODE_IR: begin
                if (sample.cmd == CMD_CAM)       next_mode = MODE_CAM;
                else if (sample.cmd == CMD_IDLE) next_mode = MODE_IDLE;
            end
            default: next_mode = MODE_IDLE;
        endcase
    end

    // Sub-state looks at the mode we are about to enter
    always_comb begin
        case (status.cam_state)
            CAM_SEARCH: begin
                if (next_mode != MODE_CAM) next_cam = CAM_PAUSE;
                else if (sample.target)    next_cam = CAM_FOLLOW;
                else                       next_cam = CAM_SEARCH;
            end
            CAM_FOLLOW: begin
                if (next_mode != MODE_CAM) next_cam = CAM_PAUSE;
                else if (!sample.target)   next_cam = CAM_SEARCH;   // Lost the target
                else                       next_cam = CAM_FOLLOW;
            end
            default: next_cam = (next_mode == MODE_CAM) ? CAM_SEARCH : CAM_PAUSE;
        endcase
    end

    always_comb begin
        next_drive = DRV_STOP;
        if (next_cam == CAM_SEARCH) begin
            next_drive = DRV_RIGHT;   // Spin in place while searching
        end else if (next_cam == CAM_FOLLOW) begin
            case (sample.cam_dir)
                3'd1: next_drive = DRV_LEFT;
                3'd2: next_drive = DRV_RIGHT;
                3'd3: begin
                    case (sample.speed)
                        2'd0:    next_drive = DRV_SLOW;
                        2'd1:    next_drive = DRV_MEDIUM;
                        2'd2:    next_drive = DRV_FAST;
                        default: next_drive = DRV_STOP;
                    endcase
                end
                default: next_drive = DRV_STOP;
            endcase
        end
    end

    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            status        <= '{mode: MODE_IDLE, cam_state: CAM_PAUSE, drive: DRV_STOP};
            track_restart <= 1'b0;
        end else begin
            status        <= '{mode: next_mode, cam_state: next_cam, drive: next_drive};
            track_restart <= (next_mode != status.mode) || (next_cam != status.cam_state);
        end
    end

endmodule

`default_nettype wire

// File: design/motor_pwm.sv
`default_nettype none

module motor_pwm #(
    parameter int PWM_PERIOD = 16
) (
    input  wire logic                    clk_50,
    input  wire logic                    rst_n,
    input  wire rover_pkg::rover_status_t status,
    output logic                         left_pwm,
    output logic                         right_pwm
);
    import rover_pkg::*;

    localparam int CNT_W  = $clog2(PWM_PERIOD);
    localparam int DUTY_W = $clog2(PWM_PERIOD + 1);   // Must hold the full period

    localparam logic [DUTY_W-1:0] DUTY_ZERO    = '0;
    localparam logic [DUTY_W-1:0] DUTY_QUARTER = DUTY_W'(PWM_PERIOD / 4);
    localparam logic [DUTY_W-1:0] DUTY_HALF    = DUTY_W'(PWM_PERIOD / 2);
    localparam logic [DUTY_W-1:0] DUTY_3Q      = DUTY_W'(3 * PWM_PERIOD / 4);
    localparam logic [DUTY_W-1:0] DUTY_FULL    = DUTY_W'(PWM_PERIOD);

    logic [CNT_W-1:0]  period_cnt;
    logic [DUTY_W-1:0] left_duty;
    logic [DUTY_W-1:0] right_duty;

    // Turning is done by running one wheel only
    always_comb begin
        case (status.drive)
            DRV_LEFT:   begin left_duty = DUTY_ZERO;    right_duty = DUTY_FULL;    end
            DRV_RIGHT:  begin left_duty = DUTY_FULL;    right_duty = DUTY_ZERO;    end
            DRV_SLOW:   begin left_duty = DUTY_QUARTER; right_duty = DUTY_QUARTER; end
            DRV_MEDIUM: begin left_duty = DUTY_HALF;    right_duty = DUTY_HALF;    end
            DRV_FAST:   begin left_duty = DUTY_3Q;      right_duty = DUTY_3Q;      end
            default:    begin left_duty = DUTY_ZERO;    right_duty = DUTY_ZERO;    end
        endcase
    end

    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            period_cnt <= '0;
            left_pwm   <= 1'b0;
            right_pwm  <= 1'b0;
        end else begin
            if (period_cnt == CNT_W'(PWM_PERIOD - 1)) begin
                period_cnt <= '0;   // Wrap at end of period
            end else begin
                period_cnt <= period_cnt + CNT_W'(1);
            end
            left_pwm  <= DUTY_W'(period_cnt) < left_duty;
            right_pwm <= DUTY_W'(period_cnt) < right_duty;
        end
    end

endmodule

`default_nettype wire

// File: design/mode_display.sv
`default_nettype none

module mode_display (
    input  wire rover_pkg::rover_status_t status,
    output rover_pkg::seg_digits_t        segs
);
    import rover_pkg::*;

    // Letters, active low
    localparam logic [6:0] SEG_I     = 7'b1111001;
    localparam logic [6:0] SEG_D     = 7'b0100001;
    localparam logic [6:0] SEG_C     = 7'b1000110;
    localparam logic [6:0] SEG_A     = 7'b0001000;
    localparam logic [6:0] SEG_R     = 7'b0101111;
    localparam logic [6:0] SEG_BLANK = 7'b1111111;

    always_comb begin
        case (status.mode)
            MODE_IDLE: begin segs.mode_hi = SEG_I;     segs.mode_lo = SEG_D;     end
            MODE_CAM:  begin segs.mode_hi = SEG_C;     segs.mode_lo = SEG_A;     end
            MODE_IR:   begin segs.mode_hi = SEG_I;     segs.mode_lo = SEG_R;     end
            default:   begin segs.mode_hi = SEG_BLANK; segs.mode_lo = SEG_BLANK; end
        endcase
    end

    // Drive state shown as its numeric code
    always_comb begin
        case (status.drive)
            DRV_STOP:   segs.drive_digit = 7'b1000000;   // 0
            DRV_LEFT:   segs.drive_digit = 7'b1111001;   // 1
            DRV_RIGHT:  segs.drive_digit = 7'b0100100;   // 2
            DRV_SLOW:   segs.drive_digit = 7'b0110000;   // 3
            DRV_MEDIUM: segs.drive_digit = 7'b0011001;   // 4
            DRV_FAST:   segs.drive_digit = 7'b0010010;   // 5
            default:    segs.drive_digit = SEG_BLANK;
        endcase
    end

endmodule

`default_nettype wire

// File: design/rover_top.sv
`default_nettype none

module rover_top #(
    parameter int TARGET_FILTER = 4,
    parameter int PWM_PERIOD    = 16   // Keep a multiple of 4
) (
    input  wire logic                 clk_50,
    input  wire logic                 rst_n,
    input  wire logic [7:0]           ir_button,
    input  wire logic [2:0]           cam_direction,
    input  wire logic [1:0]           cam_speed,
    input  wire logic                 orange_detected,
    output rover_pkg::rover_status_t  status,
    output logic                      track_restart,
    output logic                      left_pwm,
    output logic                      right_pwm,
    output rover_pkg::seg_digits_t    segs
);
    import rover_pkg::*;

    sensor_sample_t sample;   // Input side to controller

    sensor_front #(
        .TARGET_FILTER (TARGET_FILTER)
    ) sensor_front_inst (
        .clk_50          (clk_50),
        .rst_n           (rst_n),
        .ir_button       (ir_button),
        .cam_direction   (cam_direction),
        .cam_speed       (cam_speed),
        .orange_detected (orange_detected),
        .sample          (sample)
    );

    drive_mode_fsm drive_mode_fsm_inst (
        .clk_50        (clk_50),
        .rst_n         (rst_n),
        .sample        (sample),
        .status        (status),
        .track_restart (track_restart)
    );

    motor_pwm #(
        .PWM_PERIOD (PWM_PERIOD)
    ) motor_pwm_inst (
        .clk_50    (clk_50),
        .rst_n     (rst_n),
        .status    (status),
        .left_pwm  (left_pwm),
        .right_pwm (right_pwm)
    );

    mode_display mode_display_inst (
        .status (status),
        .segs   (segs)
    );

endmodule

`default_nettype wire

// File: verification/rover_sva.sv
`default_nettype none

module rover_sva (
    input wire logic                     clk_50,
    input wire logic                     rst_n,
    input wire rover_pkg::rover_status_t status,
    input wire logic                     track_restart
);
    timeunit 1ns;
    timeprecision 1ps;
    import rover_pkg::*;

    rover_mode_e mode_now;
    cam_state_e  cam_now;

    assign mode_now = status.mode;
    assign cam_now  = status.cam_state;

    // Back-to-back pulses need a fresh change
    restart_needs_change: assert property (@(posedge clk_50) disable iff (!rst_n)
        (track_restart && $past(track_restart))
            |-> (mode_now != $past(mode_now) || cam_now != $past(cam_now)))
        else $error("track_restart high twice without a new state change");

    mode_legal: assert property (@(posedge clk_50) disable iff (!rst_n) mode_now != 2'd3)
        else $error("mode reached the unused encoding");

    pause_outside_cam: assert property (@(posedge clk_50) disable iff (!rst_n)
        (mode_now != MODE_CAM) |-> (cam_now == CAM_PAUSE))
        else $error("cam_state left pause outside camera mode");

endmodule

bind drive_mode_fsm rover_sva rover_sva_inst (
    .clk_50        (clk_50),
    .rst_n         (rst_n),
    .status        (status),
    .track_restart (track_restart)
);

`default_nettype wire

// File: verification/rover_tb.sv
`default_nettype none

module rover_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rover_pkg::*;

    localparam int TARGET_FILTER = 4;
    localparam int PWM_PERIOD    = 16;
    localparam int SEGMENTS      = 24;   // Random bursts each followed by a hold
    localparam int BURST_CYCLES  = 120;
    localparam int HOLD_TIMEOUT  = 4 * PWM_PERIOD + 16;

    // Lit segments with bit 0 as segment a
    localparam logic [6:0] DIGIT_ON [6] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D};
    localparam logic [6:0] HI_ON [3]    = '{7'h06, 7'h39, 7'h06};   // I C I
    localparam logic [6:0] LO_ON [3]    = '{7'h5E, 7'h77, 7'h50};   // d A r

    logic          clk_50 = 1'b0;
    logic          rst_n;
    logic [7:0]    ir_button;
    logic [2:0]    cam_direction;
    logic [1:0]    cam_speed;
    logic          orange_detected;
    rover_status_t status;
    logic          track_restart;
    logic          left_pwm;
    logic          right_pwm;
    seg_digits_t   segs;

    // Reference model state
    mode_cmd_e   m_cmd      = CMD_NONE;
    logic [2:0]  m_dir      = 3'd0;
    logic [1:0]  m_speed    = 2'd0;
    logic        m_target   = 1'b0;
    logic        prev_orange = 1'b0;
    int          run_len    = 0;   // Length of the current orange_detected run
    rover_mode_e m_mode     = MODE_IDLE;
    cam_state_e  m_cam      = CAM_PAUSE;
    drive_e      m_drive    = DRV_STOP;
    logic        m_restart  = 1'b0;
    drive_e      held_drive = DRV_STOP;
    int          age        = 0;
    int          left_cnt   = 0;
    int          right_cnt  = 0;
    int          windows    = 0;
    int          button_left = 0;
    int          orange_left = 0;

    always #4 clk_50 = ~clk_50;

    rover_top #(
        .TARGET_FILTER (TARGET_FILTER),
        .PWM_PERIOD    (PWM_PERIOD)
    ) rover_top_inst (
        .clk_50          (clk_50),
        .rst_n           (rst_n),
        .ir_button       (ir_button),
        .cam_direction   (cam_direction),
        .cam_speed       (cam_speed),
        .orange_detected (orange_detected),
        .status          (status),
        .track_restart   (track_restart),
        .left_pwm        (left_pwm),
        .right_pwm       (right_pwm),
        .segs            (segs)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (exp === got)
        else stop_on_error($sformatf("ERR %s expected %h got %h", name, exp, got));
    endtask

    function automatic mode_cmd_e decode_button(input logic [7:0] code);
        case (code)
            8'h0F:   return CMD_CAM;
            8'h13:   return CMD_IR;
            8'h10:   return CMD_IDLE;
            default: return CMD_NONE;
        endcase
    endfunction

    function automatic drive_e expected_drive(input cam_state_e cam, input logic [2:0] dir,
                                              input logic [1:0] speed);
        if (cam == CAM_SEARCH) return DRV_RIGHT;
        if (cam != CAM_FOLLOW) return DRV_STOP;
        if (dir == 3'd1) return DRV_LEFT;
        if (dir == 3'd2) return DRV_RIGHT;
        if (dir == 3'd3 && speed != 2'd3) return drive_e'(3'd3 + 3'(speed));   // SLOW..FAST
        return DRV_STOP;
    endfunction

    function automatic int duty(input drive_e d, input bit right_wheel);
        case (d)
            DRV_LEFT:   return right_wheel ? PWM_PERIOD : 0;
            DRV_RIGHT:  return right_wheel ? 0 : PWM_PERIOD;
            DRV_SLOW:   return PWM_PERIOD / 4;
            DRV_MEDIUM: return PWM_PERIOD / 2;
            DRV_FAST:   return 3 * PWM_PERIOD / 4;
            default:    return 0;
        endcase
    endfunction

    task automatic check_outputs();
        logic [6:0] exp_hi;
        logic [6:0] exp_lo;
        logic [6:0] exp_digit;
        exp_hi    = ~HI_ON[m_mode];
        exp_lo    = ~LO_ON[m_mode];
        exp_digit = ~DIGIT_ON[m_drive];
        check_value("status.mode", 32'(m_mode), 32'(status.mode));
        check_value("status.cam_state", 32'(m_cam), 32'(status.cam_state));
        check_value("status.drive", 32'(m_drive), 32'(status.drive));
        check_value("track_restart", 32'(m_restart), 32'(track_restart));
        check_value("segs.mode_hi", 32'(exp_hi), 32'(segs.mode_hi));
        check_value("segs.mode_lo", 32'(exp_lo), 32'(segs.mode_lo));
        check_value("segs.drive_digit", 32'(exp_digit), 32'(segs.drive_digit));
        age = (m_drive == held_drive) ? age + 1 : 0;
        held_drive = m_drive;
        if (age == 0) begin
            left_cnt  = 0;   // PWM still shows the old drive here
            right_cnt = 0;
        end else begin
            left_cnt  += int'(left_pwm);
            right_cnt += int'(right_pwm);
            if (age % PWM_PERIOD == 0) begin
                check_value("left_pwm high count", duty(m_drive, 1'b0), left_cnt);
                check_value("right_pwm high count", duty(m_drive, 1'b1), right_cnt);
                windows++;
                left_cnt  = 0;   // Next window starts on the following cycle
                right_cnt = 0;
            end
        end
    endtask

    task automatic advance_model();
        rover_mode_e n_mode;
        cam_state_e  n_cam;
        n_mode = m_mode;
        case (m_cmd)
            CMD_CAM:  n_mode = MODE_CAM;
            CMD_IR:   n_mode = MODE_IR;
            CMD_IDLE: n_mode = MODE_IDLE;
            default:  n_mode = m_mode;
        endcase
        if (n_mode != MODE_CAM) n_cam = CAM_PAUSE;
        else if (m_cam == CAM_PAUSE) n_cam = CAM_SEARCH;
        else n_cam = m_target ? CAM_FOLLOW : CAM_SEARCH;
        m_drive   = expected_drive(n_cam, m_dir, m_speed);
        m_restart = (n_mode != m_mode) || (n_cam != m_cam);
        m_mode    = n_mode;
        m_cam     = n_cam;
        run_len = (run_len > 0 && orange_detected == prev_orange) ? run_len + 1 : 1;
        prev_orange = orange_detected;
        if (run_len >= TARGET_FILTER && orange_detected != m_target) m_target = orange_detected;
        m_cmd   = decode_button(ir_button);
        m_dir   = cam_direction;
        m_speed = cam_speed;
    endtask

    task automatic clock_cycle();
        @(posedge clk_50);
        check_outputs();
        advance_model();
        @(negedge clk_50);
    endtask

    task automatic drive_random();
        int pick;
        if (button_left == 0) begin
            pick = $urandom_range(0, 9);
            if (pick < 4) ir_button = 8'h0F;
            else if (pick < 6) ir_button = 8'h13;
            else if (pick < 8) ir_button = 8'h10;
            else ir_button = 8'($urandom);
            button_left = $urandom_range(1, 6);
        end
        button_left--;
        if (orange_left == 0) begin
            orange_detected = ~orange_detected;
            orange_left = $urandom_range(1, 8);
        end
        orange_left--;
        cam_direction = 3'($urandom_range(0, 7));
        cam_speed     = 2'($urandom_range(0, 3));
    endtask

    initial begin
        int waited;
        int windows_before;
        void'($urandom(6));
        rst_n           = 1'b0;
        ir_button       = 8'h00;
        cam_direction   = 3'd0;
        cam_speed       = 2'd0;
        orange_detected = 1'b0;
        repeat (10) @(posedge clk_50);
        @(negedge clk_50);
        rst_n = 1'b1;
        check_value("status", 32'({MODE_IDLE, CAM_PAUSE, DRV_STOP}), 32'(status));
        check_value("track_restart", 32'(0), 32'(track_restart));
        check_value("left_pwm", 32'(0), 32'(left_pwm));
        check_value("right_pwm", 32'(0), 32'(right_pwm));
        for (int s = 0; s < SEGMENTS; s++) begin
            repeat (BURST_CYCLES) begin
                clock_cycle();
                drive_random();
            end
            windows_before = windows;   // Inputs now stay fixed
            waited = 0;
            while (windows == windows_before && waited < HOLD_TIMEOUT) begin
                clock_cycle();
                waited++;
            end
            assert (windows != windows_before)
            else stop_on_error("No PWM window completed while the inputs were held");
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
design/rover_pkg.sv
design/sensor_front.sv
design/drive_mode_fsm.sv
design/motor_pwm.sv
design/mode_display.sv
design/rover_top.sv
verification/rover_sva.sv
verification/rover_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module rover_tb -Mdir obj_dir -f tb.f
./obj_dir/Vrover_tb
